// ==== logic/riscv_pkg.sv ====
package riscv_pkg;

    // basic widths
    typedef logic [31:0] word_t;      // data, address or instruction word
    typedef logic [4:0]  reg_addr_t;  // register index
    typedef logic [6:0]  opcode_t;

    // opcodes of the supported instructions
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // immediate format select
    typedef logic [1:0] imm_sel_t;
    localparam imm_sel_t IMM_I = 2'b00;
    localparam imm_sel_t IMM_S = 2'b01;
    localparam imm_sel_t IMM_B = 2'b10;
    localparam imm_sel_t IMM_J = 2'b11;

    // result source select, 2'b11 unused
    typedef logic [1:0] result_sel_t;
    localparam result_sel_t RES_ALU = 2'b00;
    localparam result_sel_t RES_MEM = 2'b01;
    localparam result_sel_t RES_PC4 = 2'b10;

    // coarse alu class from the main decoder
    typedef logic [1:0] alu_class_t;
    localparam alu_class_t ALU_CLASS_ADD   = 2'b00;  // address calc
    localparam alu_class_t ALU_CLASS_SUB   = 2'b01;  // beq compare
    localparam alu_class_t ALU_CLASS_FUNCT = 2'b10;  // look at funct3/funct7

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_e;

endpackage

// ==== logic/main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder (
    input  riscv_pkg::opcode_t     op_i,
    output logic                   branch_o,
    output logic                   jump_o,     // or-ed with branch&zero for the pc select
    output logic                   mem_write_o,
    output logic                   alu_src_o,  // 1 selects the immediate
    output logic                   reg_write_o,
    output riscv_pkg::result_sel_t result_src_o,
    output riscv_pkg::imm_sel_t    imm_src_o,
    output riscv_pkg::alu_class_t  alu_op_o
);

    always_comb begin
        // no-op control word, also used for unknown opcodes
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        reg_write_o  = 1'b0;
        result_src_o = riscv_pkg::RES_ALU;
        imm_src_o    = riscv_pkg::IMM_I;
        alu_op_o     = riscv_pkg::ALU_CLASS_ADD;

        case (op_i)
            riscv_pkg::OP_LOAD: begin   // lw
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = riscv_pkg::RES_MEM;
                imm_src_o    = riscv_pkg::IMM_I;
            end
            riscv_pkg::OP_STORE: begin  // sw
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = riscv_pkg::IMM_S;
            end
            riscv_pkg::OP_REG: begin
                reg_write_o = 1'b1;
                alu_op_o    = riscv_pkg::ALU_CLASS_FUNCT;
            end
            riscv_pkg::OP_IMM: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = riscv_pkg::IMM_I;
                alu_op_o    = riscv_pkg::ALU_CLASS_FUNCT;
            end
            riscv_pkg::OP_BRANCH: begin // beq, compare by subtraction
                branch_o  = 1'b1;
                imm_src_o = riscv_pkg::IMM_B;
                alu_op_o  = riscv_pkg::ALU_CLASS_SUB;
            end
            riscv_pkg::OP_JAL: begin
                jump_o       = 1'b1;
                reg_write_o  = 1'b1;
                result_src_o = riscv_pkg::RES_PC4; // link value
                imm_src_o    = riscv_pkg::IMM_J;
            end
            default: begin
                // undefined opcode falls through as a no-op
                reg_write_o = 1'b0;
                mem_write_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
    input  riscv_pkg::alu_class_t alu_class_i,
    input  logic [2:0]            funct3_i,
    input  logic                  funct7b5_i,
    input  logic                  opb5_i,      // set for register ops only
    output riscv_pkg::alu_op_e    alu_op_o
);

    logic is_sub;

    // sub needs both a register op and funct7[5], addi with a negative imm must stay add
    assign is_sub = opb5_i & funct7b5_i;

    always_comb begin
        case (alu_class_i)
            riscv_pkg::ALU_CLASS_ADD: alu_op_o = riscv_pkg::ALU_ADD;
            riscv_pkg::ALU_CLASS_SUB: alu_op_o = riscv_pkg::ALU_SUB;
            riscv_pkg::ALU_CLASS_FUNCT: begin
                case (funct3_i)
                    3'b000: begin
                        if (is_sub) begin
                            alu_op_o = riscv_pkg::ALU_SUB;
                        end else begin
                            alu_op_o = riscv_pkg::ALU_ADD;
                        end
                    end
                    3'b010:  alu_op_o = riscv_pkg::ALU_SLT;
                    3'b110:  alu_op_o = riscv_pkg::ALU_OR;
                    3'b111:  alu_op_o = riscv_pkg::ALU_AND;
                    default: alu_op_o = riscv_pkg::ALU_ADD; // unsupported funct3
                endcase
            end
            default: alu_op_o = riscv_pkg::ALU_ADD;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 we_i,
    input  riscv_pkg::reg_addr_t ra1_i,
    input  riscv_pkg::reg_addr_t ra2_i,
    input  riscv_pkg::reg_addr_t wa_i,
    input  riscv_pkg::word_t     wd_i,
    output riscv_pkg::word_t     rd1_o,
    output riscv_pkg::word_t     rd2_o
);

    riscv_pkg::word_t regs [32];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin // x0 is never written
            regs[wa_i] <= wd_i;
        end
    end

    // async read ports
    assign rd1_o = regs[ra1_i];
    assign rd2_o = regs[ra2_i];

    // x0 must read zero on both ports whatever was written before
    a_x0_zero : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ((ra1_i == '0) |-> (rd1_o == '0)) and ((ra2_i == '0) |-> (rd2_o == '0))
    ) else $error("x0 read back nonzero");

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  riscv_pkg::word_t       instr_i,
    input  riscv_pkg::word_t       result_i,
    output riscv_pkg::word_t       rd1_o,
    output riscv_pkg::word_t       rd2_o,
    output riscv_pkg::word_t       imm_ext_o,
    output riscv_pkg::alu_op_e     alu_op_o,
    output logic                   alu_src_o,
    output logic                   branch_o,
    output logic                   jump_o,
    output logic                   mem_write_o,
    output riscv_pkg::result_sel_t result_src_o
);

    riscv_pkg::opcode_t    opcode;
    riscv_pkg::reg_addr_t  rs1, rs2, rd;
    logic [2:0]            funct3;
    riscv_pkg::imm_sel_t   imm_src;
    riscv_pkg::alu_class_t alu_class;
    logic                  reg_write_dec;
    logic                  mem_write_dec;
    logic                  reg_write;

    // instruction fields
    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    main_decoder u_main_decoder (
        .op_i         (opcode),
        .branch_o     (branch_o),
        .jump_o       (jump_o),
        .mem_write_o  (mem_write_dec),
        .alu_src_o    (alu_src_o),
        .reg_write_o  (reg_write_dec),
        .result_src_o (result_src_o),
        .imm_src_o    (imm_src),
        .alu_op_o     (alu_class)
    );

    alu_decoder u_alu_decoder (
        .alu_class_i (alu_class),
        .funct3_i    (funct3),
        .funct7b5_i  (instr_i[30]),
        .opb5_i      (instr_i[5]),
        .alu_op_o    (alu_op_o)
    );

    // no writes of any kind while reset is held
    assign reg_write   = reg_write_dec & rst_n_i;
    assign mem_write_o = mem_write_dec & rst_n_i;

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (reg_write),
        .ra1_i   (rs1),
        .ra2_i   (rs2),
        .wa_i    (rd),
        .wd_i    (result_i),
        .rd1_o   (rd1_o),
        .rd2_o   (rd2_o)
    );

    always_comb begin
        case (imm_src)
            riscv_pkg::IMM_I: imm_ext_o = {{20{instr_i[31]}}, instr_i[31:20]};
            riscv_pkg::IMM_S: imm_ext_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            riscv_pkg::IMM_B: imm_ext_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                           instr_i[11:8], 1'b0};
            default:          imm_ext_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                           instr_i[30:21], 1'b0}; // jal
        endcase
    end

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  riscv_pkg::word_t   pc_i,
    input  riscv_pkg::word_t   rd1_i,
    input  riscv_pkg::word_t   rd2_i,
    input  riscv_pkg::word_t   imm_ext_i,
    input  logic               alu_src_i,
    input  riscv_pkg::alu_op_e alu_op_i,
    output riscv_pkg::word_t   alu_result_o,
    output riscv_pkg::word_t   target_o,
    output logic               zero_o
);

    riscv_pkg::word_t src_b;

    assign src_b = alu_src_i ? imm_ext_i : rd2_i;

    always_comb begin
        case (alu_op_i)
            riscv_pkg::ALU_ADD: alu_result_o = rd1_i + src_b;
            riscv_pkg::ALU_SUB: alu_result_o = rd1_i - src_b;
            riscv_pkg::ALU_AND: alu_result_o = rd1_i & src_b;
            riscv_pkg::ALU_OR:  alu_result_o = rd1_i | src_b;
            riscv_pkg::ALU_SLT: begin
                // signed compare
                alu_result_o = {31'b0, $signed(rd1_i) < $signed(src_b)};
            end
            default: alu_result_o = rd1_i + src_b;
        endcase
    end

    assign zero_o = (alu_result_o == '0);  // beq taken when equal

    // shared by beq and jal
    assign target_o = pc_i + imm_ext_i;

    // no clock here, so the op is sampled on each change of its own value
    a_alu_op_defined : assert property (
        @(alu_op_i)
        $isunknown(alu_op_i) || (alu_op_i inside {riscv_pkg::ALU_ADD, riscv_pkg::ALU_SUB,
                                                   riscv_pkg::ALU_AND, riscv_pkg::ALU_OR,
                                                   riscv_pkg::ALU_SLT})
    ) else $error("alu decoder produced an undefined op %0b", alu_op_i);

endmodule

// ==== logic/writeback_unit.sv ====
`timescale 1ns/1ps

module writeback_unit #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   mem_write_i,
    input  logic                   branch_i,
    input  logic                   jump_i,
    input  logic                   zero_i,
    input  riscv_pkg::result_sel_t result_src_i,
    input  riscv_pkg::word_t       alu_result_i,
    input  riscv_pkg::word_t       write_data_i,
    input  riscv_pkg::word_t       target_i,
    output riscv_pkg::word_t       pc_o,
    output riscv_pkg::word_t       result_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    riscv_pkg::word_t dmem [DMEM_WORDS];
    riscv_pkg::word_t read_data;
    riscv_pkg::word_t pc_q;
    riscv_pkg::word_t pc_plus4;
    riscv_pkg::word_t pc_next;
    logic [AW-1:0]    word_addr;

    assign word_addr = alu_result_i[AW+1:2]; // byte address to word index

    always_ff @(posedge clk_i) begin
        if (mem_write_i) begin
            dmem[word_addr] <= write_data_i;
        end
    end

    assign read_data = dmem[word_addr];

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_next  = (jump_i || (branch_i && zero_i)) ? target_i : pc_plus4;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    always_comb begin
        case (result_src_i)
            riscv_pkg::RES_MEM: result_o = read_data;
            riscv_pkg::RES_PC4: result_o = pc_plus4;  // jal link
            default:            result_o = alu_result_i;
        endcase
    end

    // store address comes from execute, enable from decode
    a_store_addr : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_write_i |-> (alu_result_i[1:0] == 2'b00) &&
                        (alu_result_i < riscv_pkg::word_t'(DMEM_WORDS * 4))
    ) else $error("store to bad address %h", alu_result_i);

endmodule

// ==== logic/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  riscv_pkg::word_t instr_i,
    output riscv_pkg::word_t pc_o,
    output riscv_pkg::word_t data_addr_o,   // alu result, doubles as store address
    output riscv_pkg::word_t write_data_o,  // rs2 value
    output logic             mem_write_o
);

    riscv_pkg::word_t       rd1;
    riscv_pkg::word_t       imm_ext;
    riscv_pkg::word_t       target;
    riscv_pkg::word_t       result;
    riscv_pkg::alu_op_e     alu_op;
    riscv_pkg::result_sel_t result_src;
    logic                   alu_src;
    logic                   branch;
    logic                   jump;
    logic                   zero;

    decode_unit u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .result_i     (result),
        .rd1_o        (rd1),
        .rd2_o        (write_data_o),
        .imm_ext_o    (imm_ext),
        .alu_op_o     (alu_op),
        .alu_src_o    (alu_src),
        .branch_o     (branch),
        .jump_o       (jump),
        .mem_write_o  (mem_write_o),
        .result_src_o (result_src)
    );

    execute_unit u_execute (
        .pc_i         (pc_o),
        .rd1_i        (rd1),
        .rd2_i        (write_data_o),
        .imm_ext_i    (imm_ext),
        .alu_src_i    (alu_src),
        .alu_op_i     (alu_op),
        .alu_result_o (data_addr_o),
        .target_o     (target),
        .zero_o       (zero)
    );

    writeback_unit #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_writeback (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mem_write_i  (mem_write_o),
        .branch_i     (branch),
        .jump_i       (jump),
        .zero_i       (zero),
        .result_src_i (result_src),
        .alu_result_i (data_addr_o),
        .write_data_i (write_data_o),
        .target_i     (target),
        .pc_o         (pc_o),
        .result_o     (result)
    );

endmodule

// ==== test/core_checker.sv ====
`timescale 1ns/1ps

module core_checker #(
    parameter int N_STORES = 13,
    parameter int N_PCS    = 30
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  riscv_pkg::word_t pc_i,
    input  logic             mem_write_i,
    input  riscv_pkg::word_t data_addr_i,
    input  riscv_pkg::word_t write_data_i,
    input  riscv_pkg::word_t exp_addr_i [N_STORES],
    input  riscv_pkg::word_t exp_data_i [N_STORES],
    input  riscv_pkg::word_t exp_pc_i [N_PCS],
    output int               errors_o,
    output int               stores_seen_o,
    output logic             pc_done_o
);

    int pc_idx;
    int reset_edges;

    initial begin
        errors_o      = 0;
        stores_seen_o = 0;
        pc_idx        = 0;
        reset_edges   = 0;
    end

    assign pc_done_o = (pc_idx >= N_PCS);

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            reset_edges++;
            // pc is unknown until the first reset edge has been taken
            if (reset_edges > 1 && pc_i !== '0) begin
                $display("FAIL %0t: pc_o is %h during reset", $time, pc_i);
                errors_o++;
            end
            if (mem_write_i !== 1'b0) begin
                $display("FAIL %0t: mem_write_o is %b during reset", $time, mem_write_i);
                errors_o++;
            end
        end else begin
            if (pc_idx < N_PCS) begin
                if (pc_i !== exp_pc_i[pc_idx]) begin
                    $display("FAIL %0t: step %0d pc_o %h, expected %h", $time, pc_idx, pc_i,
                             exp_pc_i[pc_idx]);
                    errors_o++;
                end
                pc_idx++;
            end
            if (mem_write_i === 1'b1) begin
                if (stores_seen_o >= N_STORES) begin
                    $display("unexpected extra store of %h to address %h at time %0t",
                             write_data_i, data_addr_i, $time);
                    errors_o++;
                end else begin
                    if (data_addr_i !== exp_addr_i[stores_seen_o] ||
                        write_data_i !== exp_data_i[stores_seen_o]) begin
                        $display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, stores_seen_o, write_data_i, data_addr_i,
                                 exp_data_i[stores_seen_o], exp_addr_i[stores_seen_o]);
                        errors_o++;
                    end
                    stores_seen_o++;
                end
            end
        end
    end

endmodule

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/1ps

module tb_riscv_core;

    localparam int CLK_PERIOD = 8;
    localparam int PROG_LEN   = 31;
    localparam int N_STORES   = 13;
    localparam int N_PCS      = 30;
    localparam int TIMEOUT_CYCLES = (PROG_LEN + 10) * 4;

    logic             clk_i;
    logic             rst_n_i;
    riscv_pkg::word_t instr_i;
    riscv_pkg::word_t pc_o;
    riscv_pkg::word_t data_addr_o;
    riscv_pkg::word_t write_data_o;
    logic             mem_write_o;

    riscv_pkg::word_t prog [PROG_LEN];
    riscv_pkg::word_t store_addr_tab [N_STORES];
    riscv_pkg::word_t store_data_tab [N_STORES];
    riscv_pkg::word_t pc_tab [N_PCS];
    int               error_count;
    int               stores_seen;
    logic             pc_done;

    riscv_core #(
        .DMEM_WORDS (64)
    ) UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .pc_o         (pc_o),
        .data_addr_o  (data_addr_o),
        .write_data_o (write_data_o),
        .mem_write_o  (mem_write_o)
    );

    core_checker #(
        .N_STORES (N_STORES),
        .N_PCS    (N_PCS)
    ) u_checker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .pc_i          (pc_o),
        .mem_write_i   (mem_write_o),
        .data_addr_i   (data_addr_o),
        .write_data_i  (write_data_o),
        .exp_addr_i    (store_addr_tab),
        .exp_data_i    (store_data_tab),
        .exp_pc_i      (pc_tab),
        .errors_o      (error_count),
        .stores_seen_o (stores_seen),
        .pc_done_o     (pc_done)
    );

    // instruction encoders, rv32i field layout
    function automatic riscv_pkg::word_t i_type(input riscv_pkg::word_t imm,
            input riscv_pkg::reg_addr_t rs1, input logic [2:0] f3,
            input riscv_pkg::reg_addr_t rd, input riscv_pkg::opcode_t op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic riscv_pkg::word_t r_type(input logic f7b5, input riscv_pkg::reg_addr_t rs2,
            input riscv_pkg::reg_addr_t rs1, input logic [2:0] f3, input riscv_pkg::reg_addr_t rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, riscv_pkg::OP_REG};
    endfunction

    function automatic riscv_pkg::word_t s_type(input riscv_pkg::word_t imm,
            input riscv_pkg::reg_addr_t rs2, input riscv_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::OP_STORE};
    endfunction

    function automatic riscv_pkg::word_t b_type(input riscv_pkg::word_t imm,
            input riscv_pkg::reg_addr_t rs2, input riscv_pkg::reg_addr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], riscv_pkg::OP_BRANCH};
    endfunction

    function automatic riscv_pkg::word_t j_type(input riscv_pkg::word_t imm,
            input riscv_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OP_JAL};
    endfunction

    function automatic riscv_pkg::word_t fetch_word(input riscv_pkg::word_t pc);
        if ($isunknown(pc)) begin
            return '0;  // opcode 0 runs as a no-op
        end else if ((pc >> 2) < PROG_LEN) begin
            return prog[pc >> 2];
        end
        return j_type(0, 0);  // self-jump past the end
    endfunction

    task automatic expect_store(input int idx, input riscv_pkg::word_t addr,
                                input riscv_pkg::word_t data);
        store_addr_tab[idx] = addr;
        store_data_tab[idx] = data;
    endtask

    task automatic load_program();
        prog[0]  = s_type(52, 0, 0);                              // on the bus during reset
        prog[1]  = i_type(12, 0, 3'b000, 1, riscv_pkg::OP_IMM);   // addi x1 = 12
        prog[2]  = i_type(-5, 0, 3'b000, 2, riscv_pkg::OP_IMM);   // addi x2 = -5
        prog[3]  = i_type(6, 1, 3'b111, 3, riscv_pkg::OP_IMM);    // andi 12&6
        prog[4]  = i_type(3, 1, 3'b110, 4, riscv_pkg::OP_IMM);    // ori 12|3
        prog[5]  = i_type(-4, 2, 3'b010, 5, riscv_pkg::OP_IMM);   // slti -5<-4
        prog[6]  = r_type(1'b0, 2, 1, 3'b000, 6);                 // add
        prog[7]  = r_type(1'b1, 2, 1, 3'b000, 7);                 // sub
        prog[8]  = r_type(1'b0, 2, 1, 3'b111, 8);                 // and
        prog[9]  = r_type(1'b0, 2, 1, 3'b110, 9);                 // or
        prog[10] = r_type(1'b0, 2, 1, 3'b010, 10);                // slt 12<-5
        prog[11] = s_type(0, 3, 0);
        prog[12] = s_type(4, 4, 0);
        prog[13] = s_type(8, 5, 0);
        prog[14] = s_type(12, 6, 0);
        prog[15] = s_type(16, 7, 0);
        prog[16] = s_type(20, 8, 0);
        prog[17] = s_type(24, 9, 0);
        prog[18] = s_type(28, 10, 0);
        prog[19] = i_type(4, 0, 3'b010, 11, riscv_pkg::OP_LOAD);  // lw back
        prog[20] = i_type(100, 11, 3'b000, 11, riscv_pkg::OP_IMM);
        prog[21] = s_type(32, 11, 0);
        prog[22] = b_type(8, 1, 1);                               // taken
        prog[23] = s_type(36, 1, 0);                              // skipped
        prog[24] = b_type(8, 2, 1);                               // not taken
        prog[25] = s_type(40, 2, 0);
        prog[26] = j_type(8, 12);                                 // jal x12
        prog[27] = s_type(44, 0, 0);                              // jumped over
        prog[28] = s_type(44, 12, 0);
        prog[29] = i_type(7, 0, 3'b000, 1, 7'b1111111);           // undefined, rd x1
        prog[30] = s_type(48, 1, 0);
    endtask

    task automatic fill_expected();
        expect_store(0, 52, 0);
        expect_store(1, 0, 4);
        expect_store(2, 4, 15);
        expect_store(3, 8, 1);
        expect_store(4, 12, 7);
        expect_store(5, 16, 17);
        expect_store(6, 20, 8);
        expect_store(7, 24, 32'hffff_ffff);
        expect_store(8, 28, 0);
        expect_store(9, 32, 115);          // loaded 15 plus 100
        expect_store(10, 40, 32'hffff_fffb);
        expect_store(11, 44, 108);         // link of jal at 104
        expect_store(12, 48, 12);          // x1 untouched by the undefined word
        for (int i = 0; i < 23; i++) begin
            pc_tab[i] = 4 * i;
        end
        pc_tab[23] = 96;
        pc_tab[24] = 100;
        pc_tab[25] = 104;
        pc_tab[26] = 112;
        pc_tab[27] = 116;
        pc_tab[28] = 120;
        pc_tab[29] = 124;
    endtask

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // instruction feed, 1 ns after each edge
    initial begin
        instr_i = '0;
        forever begin
            @(posedge clk_i);
            #1;
            instr_i = fetch_word(pc_o);
        end
    end

    initial begin
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        load_program();
        fill_expected();
        repeat (5) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        wait (stores_seen == N_STORES && pc_done);
        repeat (4) @(posedge clk_i);  // room for a stray store
        $display("errors: %0d, stores seen: %0d of %0d", error_count, stores_seen, N_STORES);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout after %0t, only %0d of %0d expected stores seen",
                 $time, stores_seen, N_STORES);
        $display("errors: %0d, stores seen: %0d of %0d", error_count + 1, stores_seen, N_STORES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== riscv_single.f ====
logic/riscv_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/writeback_unit.sv
logic/riscv_core.sv
test/core_checker.sv
test/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_single

sources:
  - logic/riscv_pkg.sv
  - logic/main_decoder.sv
  - logic/alu_decoder.sv
  - logic/reg_file.sv
  - logic/decode_unit.sv
  - logic/execute_unit.sv
  - logic/writeback_unit.sv
  - logic/riscv_core.sv
  - target: test
    files:
      - test/core_checker.sv
      - test/tb_riscv_core.sv
